// ==== lc4_pipeline.f ====
src/lc4_pkg.sv
src/lc4_decoder.sv
src/lc4_regfile.sv
src/lc4_alu.sv
src/lc4_bypass.sv
src/lc4_pipeline.sv
sim/lc4_checker.sv
sim/tb_clock.sv
sim/tb_lc4.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the LC4 pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f lc4_pipeline.f --top-module tb_lc4

out="$(./obj_dir/Vtb_lc4 2>&1 || true)"
echo "$out"

if grep -q -F -x "Done: no errors" <<< "$out"; then
   exit 0
else
   exit 1
fi

// ==== sim/lc4_checker.sv ====
// Concurrent assertions on the LC4 pipeline ports, bound into lc4_pipeline
`timescale 1ns/1ns

module lc4_checker (
   input logic           gwe,
   input logic           i_arst_n,
   input logic           i_dmem_we,
   input logic           i_wb_rf_we,
   input logic           i_wb_valid,
   input lc4_pkg::word_t i_imem_addr
);

   // Store enable is always a clean level
   a_dmem_we_known: assert property (@(posedge gwe) disable iff (!i_arst_n)
      !$isunknown(i_dmem_we))
      else $error("o_dmem_we is unknown");

   // Register writes only retire with a valid instruction
   a_wb_we_valid: assert property (@(posedge gwe) disable iff (!i_arst_n)
      i_wb_rf_we |-> i_wb_valid)
      else $error("o_wb_rf_we high without o_wb_valid");

   // Straight-line fetch, one word per cycle
   a_pc_step: assert property (@(posedge gwe) disable iff (!i_arst_n)
      $past(i_arst_n) |-> (i_imem_addr == lc4_pkg::word_t'($past(i_imem_addr) + 16'd1)))
      else $error("o_imem_addr did not advance by one");

endmodule

bind lc4_pipeline lc4_checker u_checker (
   .gwe         (gwe),
   .i_arst_n    (i_arst_n),
   .i_dmem_we   (o_dmem_we),
   .i_wb_rf_we  (o_wb_rf_we),
   .i_wb_valid  (o_wb_valid),
   .i_imem_addr (o_imem_addr)
);

// ==== sim/tb_clock.sv ====
// Testbench clock and reset source with a 10 ns gwe and an active-low reset held for 10 cycles
`timescale 1ns/1ns

module tb_clock (
   output logic o_gwe,
   output logic o_arst_n
);

   initial begin
      o_gwe    = 1'b0;
      o_arst_n = 1'b0;
      forever #5 o_gwe = ~o_gwe;
   end

   // Reset released on the tenth rising edge
   initial begin
      repeat (10) @(posedge o_gwe);
      o_arst_n <= 1'b1;
   end

endmodule

// ==== sim/tb_lc4.sv ====
// LC4 pipeline testbench with memory models, golden model, compare tasks, directed tests and watchdog
`timescale 1ns/1ns

module tb_lc4;

   // Upper bound of fetched slots over all tests including gaps
   localparam int MAX_INSNS = 80;

   logic              gwe, i_arst_n;
   lc4_pkg::word_t    o_imem_addr, i_imem_insn, o_dmem_addr, o_dmem_wdata, i_dmem_rdata;
   lc4_pkg::word_t    o_wb_pc, o_wb_insn, o_wb_rf_wdata;
   logic              o_dmem_we, o_wb_valid, o_wb_rf_we;
   lc4_pkg::reg_sel_t o_wb_rf_wsel;

   // Program image and per-slot expectations
   lc4_pkg::word_t    imem [128];
   logic              exp_we [128];
   lc4_pkg::reg_sel_t exp_wsel [128];
   lc4_pkg::word_t    exp_wdata [128];
   logic [6:0]        wr_slot;
   // Data memory and golden state
   lc4_pkg::word_t    dmem [256];
   lc4_pkg::word_t    gmem [256];
   lc4_pkg::word_t    gold [8];
   lc4_pkg::word_t    st_addr_q [$];
   lc4_pkg::word_t    st_data_q [$];
   logic [31:0]       lcg_state;
   int                errors;

   tb_clock u_clock (.o_gwe(gwe), .o_arst_n(i_arst_n));

   lc4_pipeline i_dut (
      .gwe(gwe), .i_arst_n(i_arst_n),
      .o_imem_addr(o_imem_addr), .i_imem_insn(i_imem_insn),
      .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we),
      .o_dmem_wdata(o_dmem_wdata), .i_dmem_rdata(i_dmem_rdata),
      .o_wb_valid(o_wb_valid), .o_wb_pc(o_wb_pc), .o_wb_insn(o_wb_insn),
      .o_wb_rf_we(o_wb_rf_we), .o_wb_rf_wsel(o_wb_rf_wsel), .o_wb_rf_wdata(o_wb_rf_wdata)
   );

   // Single-cycle memories; outside the program window reads as opcode 0
   always_comb begin
      lc4_pkg::word_t idx;
      idx = o_imem_addr - lc4_pkg::RESET_PC;
      i_imem_insn = (idx < 16'd128) ? imem[idx[6:0]] : '0;
   end
   assign i_dmem_rdata = dmem[o_dmem_addr[7:0]];
   always @(posedge gwe) begin
      if (o_dmem_we) dmem[o_dmem_addr[7:0]] <= o_dmem_wdata;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic check_word(input string what, input lc4_pkg::word_t got,
                             input lc4_pkg::word_t exp);
      if (got !== exp) begin
         errors++;
         abort_run($sformatf("FAIL t=%0t %s got %h expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_sel(input string what, input lc4_pkg::reg_sel_t got,
                            input lc4_pkg::reg_sel_t exp);
      if (got !== exp) begin
         errors++;
         abort_run($sformatf("FAIL t=%0t %s got r%0d expected r%0d", $time, what, got, exp));
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         abort_run($sformatf("FAIL t=%0t %s got %b expected %b", $time, what, got, exp));
      end
   endtask

   // Instruction encoders
   function automatic lc4_pkg::word_t enc_rrr(input lc4_pkg::opcode_e op, input int rd,
                                              input int rs, input int sub, input int rt);
      return {op, 3'(rd), 3'(rs), 3'(sub), 3'(rt)};
   endfunction

   function automatic lc4_pkg::word_t enc_imm(input lc4_pkg::opcode_e op, input int rd,
                                              input int rs, input logic [5:0] imm);
      return {op, 3'(rd), 3'(rs), imm};
   endfunction

   function automatic lc4_pkg::word_t enc_const(input int rd, input logic [8:0] imm9);
      return {lc4_pkg::OP_CONST, 3'(rd), imm9};
   endfunction

   // Golden model executed in program order as instructions are placed
   task automatic model_exec(input logic [6:0] slot, input lc4_pkg::word_t insn);
      lc4_pkg::reg_sel_t rd, rs, rt;
      logic [2:0]        sub;
      lc4_pkg::word_t    a, b, i5, i6, i9, res, addr;
      logic              we;
      rd  = insn[11:9];
      rs  = insn[8:6];
      rt  = insn[2:0];
      sub = insn[5:3];
      a   = gold[rs];
      b   = gold[rt];
      i5  = {{11{insn[4]}}, insn[4:0]};
      i6  = {{10{insn[5]}}, insn[5:0]};
      i9  = {{7{insn[8]}}, insn[8:0]};
      res = '0;
      we  = 1'b1;
      case (lc4_pkg::opcode_e'(insn[15:12]))
         lc4_pkg::OP_ARITH: begin
            if (insn[5]) res = a + i5;
            else if (sub == 3'd0) res = a + b;
            else if (sub == 3'd2) res = a - b;
            else we = 1'b0;
         end
         lc4_pkg::OP_LOGIC: begin
            if (insn[5]) res = a & i5;
            else if (sub == 3'd0) res = a & b;
            else if (sub == 3'd1) res = ~a;
            else if (sub == 3'd2) res = a | b;
            else if (sub == 3'd3) res = a ^ b;
            else we = 1'b0;
         end
         lc4_pkg::OP_LDR: begin
            addr = a + i6;
            res  = gmem[addr[7:0]];
         end
         lc4_pkg::OP_STR: begin
            // Store data register sits in the rd field
            addr = a + i6;
            gmem[addr[7:0]] = gold[rd];
            st_addr_q.push_back(addr);
            st_data_q.push_back(gold[rd]);
            we = 1'b0;
         end
         lc4_pkg::OP_CONST: res = i9;
         default: we = 1'b0;
      endcase
      exp_we[slot]    = we;
      exp_wsel[slot]  = rd;
      exp_wdata[slot] = res;
      if (we) gold[rd] = res;
   endtask

   task automatic emit(input lc4_pkg::word_t insn);
      imem[wr_slot] = insn;
      model_exec(wr_slot, insn);
      wr_slot++;
   endtask

   // Place the next program two slots past the fetch point
   task automatic begin_program();
      lc4_pkg::word_t cur;
      @(negedge gwe);
      cur = o_imem_addr - lc4_pkg::RESET_PC;
      wr_slot = cur[6:0] + 7'd2;
   endtask

   task automatic check_retire();
      lc4_pkg::word_t slot_w;
      logic [6:0]     slot;
      slot_w = o_wb_pc - lc4_pkg::RESET_PC;
      slot = slot_w[6:0];
      check_word("retired insn", o_wb_insn, imem[slot]);
      check_bit("o_wb_rf_we", o_wb_rf_we, exp_we[slot]);
      if (exp_we[slot]) begin
         check_sel("o_wb_rf_wsel", o_wb_rf_wsel, exp_wsel[slot]);
         check_word("o_wb_rf_wdata", o_wb_rf_wdata, exp_wdata[slot]);
      end
   endtask

   // Sample on falling edges until the last placed slot retires
   task automatic run_program();
      lc4_pkg::word_t last_pc;
      logic           done;
      last_pc = lc4_pkg::RESET_PC + lc4_pkg::word_t'(wr_slot) - 16'd1;
      done = 1'b0;
      while (!done) begin
         @(negedge gwe);
         if (o_dmem_we) begin
            if (st_addr_q.size() == 0) begin
               abort_run("A store appeared on the data port that the program does not contain");
            end
            check_word("o_dmem_addr", o_dmem_addr, st_addr_q.pop_front());
            check_word("o_dmem_wdata", o_dmem_wdata, st_data_q.pop_front());
         end
         if (o_wb_valid) begin
            check_retire();
            done = (o_wb_pc == last_pc);
         end
      end
   endtask

   task automatic test_reset_and_first_retire();
      wr_slot = '0;
      emit(enc_const(0, 9'(lcg_next())));
      @(posedge i_arst_n);
      // First fetch cycle after release
      @(negedge gwe);
      check_word("o_imem_addr after reset", o_imem_addr, lc4_pkg::RESET_PC);
      check_bit("o_wb_valid before first retire", o_wb_valid, 1'b0);
      repeat (3) begin
         @(negedge gwe);
         check_bit("o_wb_valid before first retire", o_wb_valid, 1'b0);
      end
      @(negedge gwe);
      check_bit("o_wb_valid at first retire", o_wb_valid, 1'b1);
      check_word("first o_wb_pc", o_wb_pc, lc4_pkg::RESET_PC);
      check_retire();
   endtask

   task automatic test_alu_ops();
      begin_program();
      for (int r = 0; r < 4; r++) emit(enc_const(r, 9'(lcg_next())));
      emit(enc_rrr(lc4_pkg::OP_ARITH, 4, 0, 0, 1));
      emit(enc_rrr(lc4_pkg::OP_ARITH, 5, 2, 2, 3));
      emit(enc_imm(lc4_pkg::OP_ARITH, 6, 0, {1'b1, 5'(lcg_next())}));
      emit(enc_rrr(lc4_pkg::OP_LOGIC, 7, 1, 0, 2));
      emit(enc_rrr(lc4_pkg::OP_LOGIC, 4, 3, 1, 0));
      emit(enc_rrr(lc4_pkg::OP_LOGIC, 5, 0, 2, 3));
      emit(enc_rrr(lc4_pkg::OP_LOGIC, 6, 1, 3, 3));
      emit(enc_imm(lc4_pkg::OP_LOGIC, 7, 2, {1'b1, 5'(lcg_next())}));
      run_program();
   endtask

   // Distance 1 is M-to-X, 2 is W-to-X, 3 is register file write-through
   task automatic test_bypass_chain();
      begin_program();
      emit(enc_const(1, 9'(lcg_next())));
      emit(enc_imm(lc4_pkg::OP_ARITH, 2, 1, {1'b1, 5'(lcg_next())}));
      emit(enc_rrr(lc4_pkg::OP_LOGIC, 5, 0, 1, 0));
      emit(enc_rrr(lc4_pkg::OP_ARITH, 3, 2, 2, 1));
      emit(enc_rrr(lc4_pkg::OP_LOGIC, 6, 0, 1, 0));
      emit(enc_rrr(lc4_pkg::OP_LOGIC, 7, 0, 1, 0));
      emit(enc_rrr(lc4_pkg::OP_LOGIC, 4, 3, 3, 2));
      emit(enc_rrr(lc4_pkg::OP_ARITH, 4, 4, 0, 4));
      run_program();
   endtask

   task automatic test_store_load();
      begin_program();
      emit(enc_const(1, 9'd40 + 9'(lcg_next() % 64)));
      emit(enc_const(2, 9'(lcg_next())));
      emit(enc_imm(lc4_pkg::OP_STR, 2, 1, 6'd5));
      emit(enc_rrr(lc4_pkg::OP_LOGIC, 5, 5, 1, 0));
      emit(enc_imm(lc4_pkg::OP_LDR, 3, 1, 6'd5));
      emit(enc_rrr(lc4_pkg::OP_LOGIC, 6, 6, 1, 0));
      emit(enc_rrr(lc4_pkg::OP_ARITH, 4, 3, 0, 3));
      run_program();
      if (st_addr_q.size() != 0) abort_run("The expected store never reached the data port");
   endtask

   task automatic test_unsupported_opcode();
      begin_program();
      emit(enc_const(3, 9'(lcg_next())));
      emit({4'd12, 3'd3, 9'(lcg_next())});
      emit(enc_rrr(lc4_pkg::OP_ARITH, 4, 3, 0, 3));
      run_program();
   endtask

   initial begin
      lcg_state = 32'hb9b9ad9d;
      errors = 0;
      for (int i = 0; i < 128; i++) begin
         imem[i] = '0;
         exp_we[i] = 1'b0;
         exp_wsel[i] = '0;
         exp_wdata[i] = '0;
      end
      // Address-dependent fill for the data memory
      for (int i = 0; i < 256; i++) begin
         dmem[i] = lc4_pkg::word_t'(i) * 16'h0101 ^ 16'ha5c3;
         gmem[i] = dmem[i];
      end
      for (int i = 0; i < 8; i++) gold[i] = '0;
      test_reset_and_first_retire();
      test_alu_ops();
      test_bypass_chain();
      test_store_load();
      test_unsupported_opcode();
      if (errors == 0) begin
         $display("Done: no errors");
         $finish;
      end else begin
         $display("Done: errors found");
         $fatal(1);
      end
   end

   initial begin
      #((MAX_INSNS + 20) * 10 * 2 + 100);
      abort_run("Timeout: the pipeline did not retire all test instructions in time");
   end

endmodule

// ==== src/lc4_alu.sv ====
// LC4 ALU: arithmetic, logic, CONST and load/store address generation
`timescale 1ns/1ns

module lc4_alu (
   input  lc4_pkg::word_t i_insn,
   input  lc4_pkg::word_t i_rs_data,
   input  lc4_pkg::word_t i_rt_data,
   output lc4_pkg::word_t o_result
);

   lc4_pkg::opcode_e opcode;
   logic [2:0]       subop;
   lc4_pkg::word_t   imm5_sx;
   lc4_pkg::word_t   imm6_sx;
   lc4_pkg::word_t   imm9_sx;

   assign opcode = lc4_pkg::opcode_e'(i_insn[lc4_pkg::OPC_MSB:lc4_pkg::OPC_LSB]);
   assign subop  = i_insn[lc4_pkg::SUBOP_MSB:lc4_pkg::SUBOP_LSB];

   // Sign-extended immediates, all anchored at bit 0
   assign imm5_sx = {{(lc4_pkg::WORD_W - lc4_pkg::IMM5_W){i_insn[lc4_pkg::IMM5_W-1]}},
                     i_insn[lc4_pkg::IMM5_W-1:0]};
   assign imm6_sx = {{(lc4_pkg::WORD_W - lc4_pkg::IMM6_W){i_insn[lc4_pkg::IMM6_W-1]}},
                     i_insn[lc4_pkg::IMM6_W-1:0]};
   assign imm9_sx = {{(lc4_pkg::WORD_W - lc4_pkg::IMM9_W){i_insn[lc4_pkg::IMM9_W-1]}},
                     i_insn[lc4_pkg::IMM9_W-1:0]};

   always_comb begin
      o_result = '0;
      case (opcode)
         lc4_pkg::OP_ARITH: begin
            if (i_insn[lc4_pkg::IMM_FLAG_BIT]) begin
               o_result = i_rs_data + imm5_sx;
            end else if (subop == lc4_pkg::ARITH_ADD) begin
               o_result = i_rs_data + i_rt_data;
            end else if (subop == lc4_pkg::ARITH_SUB) begin
               o_result = i_rs_data - i_rt_data;
            end
         end
         lc4_pkg::OP_LOGIC: begin
            if (i_insn[lc4_pkg::IMM_FLAG_BIT]) begin
               o_result = i_rs_data & imm5_sx;
            end else begin
               case (subop)
                  lc4_pkg::LOGIC_AND: o_result = i_rs_data & i_rt_data;
                  lc4_pkg::LOGIC_NOT: o_result = ~i_rs_data;
                  lc4_pkg::LOGIC_OR:  o_result = i_rs_data | i_rt_data;
                  lc4_pkg::LOGIC_XOR: o_result = i_rs_data ^ i_rt_data;
                  default: ;
               endcase
            end
         end
         // Effective address for the M stage
         lc4_pkg::OP_LDR, lc4_pkg::OP_STR: o_result = i_rs_data + imm6_sx;
         lc4_pkg::OP_CONST: o_result = imm9_sx;
         default: ;
      endcase
   end

endmodule

// ==== src/lc4_bypass.sv ====
// LC4 operand bypass: M-to-X and W-to-X forwarding in front of the ALU
`timescale 1ns/1ns

module lc4_bypass (
   input  lc4_pkg::reg_sel_t i_rs_sel,
   input  lc4_pkg::reg_sel_t i_rt_sel,
   input  logic              i_rs_re,
   input  logic              i_rt_re,
   input  lc4_pkg::word_t    i_rs_data,
   input  lc4_pkg::word_t    i_rt_data,
   input  lc4_pkg::reg_sel_t i_m_wsel,
   input  logic              i_m_we,
   input  lc4_pkg::word_t    i_m_data,
   input  lc4_pkg::reg_sel_t i_w_wsel,
   input  logic              i_w_we,
   input  lc4_pkg::word_t    i_w_data,
   output lc4_pkg::word_t    o_rs_data,
   output lc4_pkg::word_t    o_rt_data
);

   // Younger producer in M beats older one in W
   function automatic lc4_pkg::word_t pick(input lc4_pkg::reg_sel_t sel, input logic re,
                                          input lc4_pkg::word_t d_val);
      if (re && i_m_we && (sel == i_m_wsel)) begin
         return i_m_data;
      end else if (re && i_w_we && (sel == i_w_wsel)) begin
         return i_w_data;
      end
      return d_val;
   endfunction

   assign o_rs_data = pick(i_rs_sel, i_rs_re, i_rs_data);
   assign o_rt_data = pick(i_rt_sel, i_rt_re, i_rt_data);

endmodule

// ==== src/lc4_decoder.sv ====
// LC4 instruction decoder: register selects, read and write enables, load and store flags
`timescale 1ns/1ns

module lc4_decoder (
   input  lc4_pkg::word_t    i_insn,
   output lc4_pkg::reg_sel_t o_rs_sel,
   output lc4_pkg::reg_sel_t o_rt_sel,
   output logic              o_rs_re,
   output logic              o_rt_re,
   output lc4_pkg::reg_sel_t o_wsel,
   output logic              o_rf_we,
   output logic              o_is_load,
   output logic              o_is_store
);

   lc4_pkg::opcode_e opcode;
   logic [2:0]       subop;
   logic             imm_form;

   assign opcode   = lc4_pkg::opcode_e'(i_insn[lc4_pkg::OPC_MSB:lc4_pkg::OPC_LSB]);
   assign subop    = i_insn[lc4_pkg::SUBOP_MSB:lc4_pkg::SUBOP_LSB];
   assign imm_form = i_insn[lc4_pkg::IMM_FLAG_BIT];

   // Destination is always the rd field
   assign o_wsel   = i_insn[lc4_pkg::RD_MSB:lc4_pkg::RD_LSB];
   assign o_rs_sel = i_insn[lc4_pkg::RS_MSB:lc4_pkg::RS_LSB];

   // STR takes its data register from the rd field
   assign o_rt_sel = (opcode == lc4_pkg::OP_STR) ? i_insn[lc4_pkg::RD_MSB:lc4_pkg::RD_LSB]
                                                 : i_insn[lc4_pkg::RT_MSB:lc4_pkg::RT_LSB];

   always_comb begin
      // Default: no-op, nothing read or written
      o_rs_re    = 1'b0;
      o_rt_re    = 1'b0;
      o_rf_we    = 1'b0;
      o_is_load  = 1'b0;
      o_is_store = 1'b0;
      case (opcode)
         lc4_pkg::OP_ARITH: begin
            if (imm_form) begin
               // ADDI
               o_rs_re = 1'b1;
               o_rf_we = 1'b1;
            end else if (subop == lc4_pkg::ARITH_ADD || subop == lc4_pkg::ARITH_SUB) begin
               o_rs_re = 1'b1;
               o_rt_re = 1'b1;
               o_rf_we = 1'b1;
            end
         end
         lc4_pkg::OP_LOGIC: begin
            // ANDI and NOT need rs only; MUL-like gaps stay no-ops
            if (imm_form || subop == lc4_pkg::LOGIC_NOT) begin
               o_rs_re = 1'b1;
               o_rf_we = 1'b1;
            end else if (subop == lc4_pkg::LOGIC_AND || subop == lc4_pkg::LOGIC_OR ||
                         subop == lc4_pkg::LOGIC_XOR) begin
               o_rs_re = 1'b1;
               o_rt_re = 1'b1;
               o_rf_we = 1'b1;
            end
         end
         lc4_pkg::OP_LDR: begin
            o_rs_re   = 1'b1;
            o_rf_we   = 1'b1;
            o_is_load = 1'b1;
         end
         lc4_pkg::OP_STR: begin
            // Base in rs, data in rt
            o_rs_re    = 1'b1;
            o_rt_re    = 1'b1;
            o_is_store = 1'b1;
         end
         lc4_pkg::OP_CONST: o_rf_we = 1'b1;
         default: ;
      endcase
   end

endmodule

// ==== src/lc4_pipeline.sv ====
// LC4 five-stage pipeline top: PC, stage registers, valid bits, data port, writeback trace
`timescale 1ns/1ns

module lc4_pipeline (
   input  logic              gwe,
   input  logic              i_arst_n,
   output lc4_pkg::word_t    o_imem_addr,
   input  lc4_pkg::word_t    i_imem_insn,
   output lc4_pkg::word_t    o_dmem_addr,
   output logic              o_dmem_we,
   output lc4_pkg::word_t    o_dmem_wdata,
   input  lc4_pkg::word_t    i_dmem_rdata,
   output logic              o_wb_valid,
   output lc4_pkg::word_t    o_wb_pc,
   output lc4_pkg::word_t    o_wb_insn,
   output logic              o_wb_rf_we,
   output lc4_pkg::reg_sel_t o_wb_rf_wsel,
   output lc4_pkg::word_t    o_wb_rf_wdata
);

   // Fetch
   lc4_pkg::word_t    pc;
   // Decode
   logic              d_valid;
   lc4_pkg::word_t    d_pc, d_insn;
   lc4_pkg::reg_sel_t dec_rs_sel, dec_rt_sel, dec_wsel;
   logic              dec_rs_re, dec_rt_re, dec_rf_we, dec_is_load, dec_is_store;
   lc4_pkg::word_t    rf_rs_data, rf_rt_data;
   // Execute
   logic              x_valid, x_rs_re, x_rt_re, x_rf_we, x_is_load, x_is_store;
   lc4_pkg::word_t    x_pc, x_insn, x_rs_data, x_rt_data;
   lc4_pkg::reg_sel_t x_rs_sel, x_rt_sel, x_wsel;
   lc4_pkg::word_t    byp_rs_data, byp_rt_data, alu_result;
   // Memory
   logic              m_valid, m_rf_we, m_is_load, m_is_store;
   lc4_pkg::word_t    m_pc, m_insn, m_alu, m_store_data;
   lc4_pkg::reg_sel_t m_wsel;
   // Writeback
   logic              w_valid, w_rf_we, w_is_load;
   lc4_pkg::word_t    w_pc, w_insn, w_alu, w_mem_data, w_wdata;
   lc4_pkg::reg_sel_t w_wsel;

   // PC runs straight ahead, no control flow in this subset
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc <= lc4_pkg::RESET_PC;
      end else begin
         pc <= pc + lc4_pkg::word_t'(1);
      end
   end

   assign o_imem_addr = pc;

   // Valid bits and enables; enables are qualified by d_valid on entry to X
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         d_valid    <= 1'b0;
         x_valid    <= 1'b0;
         x_rs_re    <= 1'b0;
         x_rt_re    <= 1'b0;
         x_rf_we    <= 1'b0;
         x_is_load  <= 1'b0;
         x_is_store <= 1'b0;
         m_valid    <= 1'b0;
         m_rf_we    <= 1'b0;
         m_is_load  <= 1'b0;
         m_is_store <= 1'b0;
         w_valid    <= 1'b0;
         w_rf_we    <= 1'b0;
         w_is_load  <= 1'b0;
      end else begin
         // Every fetch after reset is real
         d_valid    <= 1'b1;
         x_valid    <= d_valid;
         x_rs_re    <= d_valid & dec_rs_re;
         x_rt_re    <= d_valid & dec_rt_re;
         x_rf_we    <= d_valid & dec_rf_we;
         x_is_load  <= d_valid & dec_is_load;
         x_is_store <= d_valid & dec_is_store;
         m_valid    <= x_valid;
         m_rf_we    <= x_rf_we;
         m_is_load  <= x_is_load;
         m_is_store <= x_is_store;
         w_valid    <= m_valid;
         w_rf_we    <= m_rf_we;
         w_is_load  <= m_is_load;
      end
   end

   // Payload registers
   always_ff @(posedge gwe) begin
      d_pc         <= pc;
      d_insn       <= i_imem_insn;
      x_pc         <= d_pc;
      x_insn       <= d_insn;
      x_rs_sel     <= dec_rs_sel;
      x_rt_sel     <= dec_rt_sel;
      x_wsel       <= dec_wsel;
      x_rs_data    <= rf_rs_data;
      x_rt_data    <= rf_rt_data;
      m_pc         <= x_pc;
      m_insn       <= x_insn;
      m_wsel       <= x_wsel;
      m_alu        <= alu_result;
      // Store data after forwarding
      m_store_data <= byp_rt_data;
      w_pc         <= m_pc;
      w_insn       <= m_insn;
      w_wsel       <= m_wsel;
      w_alu        <= m_alu;
      w_mem_data   <= i_dmem_rdata;
   end

   lc4_decoder u_decoder (
      .i_insn     (d_insn),
      .o_rs_sel   (dec_rs_sel),
      .o_rt_sel   (dec_rt_sel),
      .o_rs_re    (dec_rs_re),
      .o_rt_re    (dec_rt_re),
      .o_wsel     (dec_wsel),
      .o_rf_we    (dec_rf_we),
      .o_is_load  (dec_is_load),
      .o_is_store (dec_is_store)
   );

   // Written from W, read in D
   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_arst_n  (i_arst_n),
      .i_rs_sel  (dec_rs_sel),
      .i_rt_sel  (dec_rt_sel),
      .i_wsel    (w_wsel),
      .i_we      (w_rf_we),
      .i_wdata   (w_wdata),
      .o_rs_data (rf_rs_data),
      .o_rt_data (rf_rt_data)
   );

   // M forwards its ALU value; a load in M is never a source here
   lc4_bypass u_bypass (
      .i_rs_sel  (x_rs_sel),
      .i_rt_sel  (x_rt_sel),
      .i_rs_re   (x_rs_re),
      .i_rt_re   (x_rt_re),
      .i_rs_data (x_rs_data),
      .i_rt_data (x_rt_data),
      .i_m_wsel  (m_wsel),
      .i_m_we    (m_rf_we),
      .i_m_data  (m_alu),
      .i_w_wsel  (w_wsel),
      .i_w_we    (w_rf_we),
      .i_w_data  (w_wdata),
      .o_rs_data (byp_rs_data),
      .o_rt_data (byp_rt_data)
   );

   lc4_alu u_alu (
      .i_insn    (x_insn),
      .i_rs_data (byp_rs_data),
      .i_rt_data (byp_rt_data),
      .o_result  (alu_result)
   );

   // Data port, address only driven for memory ops
   assign o_dmem_addr  = (m_is_load | m_is_store) ? m_alu : '0;
   assign o_dmem_we    = m_is_store;
   assign o_dmem_wdata = m_store_data;

   // Writeback mux
   assign w_wdata = w_is_load ? w_mem_data : w_alu;

   // Trace
   assign o_wb_valid    = w_valid;
   assign o_wb_pc       = w_pc;
   assign o_wb_insn     = w_insn;
   assign o_wb_rf_we    = w_rf_we;
   assign o_wb_rf_wsel  = w_wsel;
   assign o_wb_rf_wdata = w_wdata;

endmodule

// ==== src/lc4_pkg.sv ====
// LC4 package: word and register index types, reset PC, opcode and sub-opcode enums, fields
package lc4_pkg;

   // Machine word and register file sizing
   localparam int WORD_W    = 16;
   localparam int REG_SEL_W = 3;
   localparam int NUM_REGS  = 8;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_SEL_W-1:0] reg_sel_t;

   // First fetch address after reset
   localparam word_t RESET_PC = 16'h8200;

   // Opcode field
   localparam int OPC_MSB = 15;
   localparam int OPC_LSB = 12;

   // Register fields, rd doubles as the store data register for STR
   localparam int RD_MSB = 11;
   localparam int RD_LSB = 9;
   localparam int RS_MSB = 8;
   localparam int RS_LSB = 6;
   localparam int RT_MSB = 2;
   localparam int RT_LSB = 0;

   // Sub-opcode of ARITH and LOGIC, bit 5 selects the imm5 form
   localparam int SUBOP_MSB    = 5;
   localparam int SUBOP_LSB    = 3;
   localparam int IMM_FLAG_BIT = 5;

   // Immediate widths, all sign-extended
   localparam int IMM5_W = 5;
   localparam int IMM6_W = 6;
   localparam int IMM9_W = 9;

   // Supported opcodes; anything else retires as a no-op
   typedef enum logic [3:0] {
      OP_ARITH = 4'd1,
      OP_LOGIC = 4'd5,
      OP_LDR   = 4'd6,
      OP_STR   = 4'd7,
      OP_CONST = 4'd9
   } opcode_e;

   // ARITH register forms
   typedef enum logic [2:0] {
      ARITH_ADD = 3'd0,
      ARITH_SUB = 3'd2
   } arith_e;

   // LOGIC register forms
   typedef enum logic [2:0] {
      LOGIC_AND = 3'd0,
      LOGIC_NOT = 3'd1,
      LOGIC_OR  = 3'd2,
      LOGIC_XOR = 3'd3
   } logic_e;

endpackage

// ==== src/lc4_regfile.sv ====
// LC4 register file: eight words, two combinational read ports, write-through from writeback
`timescale 1ns/1ns

module lc4_regfile (
   input  logic              gwe,
   input  logic              i_arst_n,
   input  lc4_pkg::reg_sel_t i_rs_sel,
   input  lc4_pkg::reg_sel_t i_rt_sel,
   input  lc4_pkg::reg_sel_t i_wsel,
   input  logic              i_we,
   input  lc4_pkg::word_t    i_wdata,
   output lc4_pkg::word_t    o_rs_data,
   output lc4_pkg::word_t    o_rt_data
);

   lc4_pkg::word_t regs [lc4_pkg::NUM_REGS];

   // Registers come up as zero
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < lc4_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_wsel] <= i_wdata;
      end
   end

   // Same-cycle write wins over the stored value
   assign o_rs_data = (i_we && (i_rs_sel == i_wsel)) ? i_wdata : regs[i_rs_sel];
   assign o_rt_data = (i_we && (i_rt_sel == i_wsel)) ? i_wdata : regs[i_rt_sel];

endmodule
